// File: build.f
+incdir+logic
logic/pcie_tx_pkg.sv
logic/tx_arbiter.sv
logic/tx_beat_capture.sv
logic/tx_fifo.sv
logic/axis_tx_out.sv
logic/pcie_tx.sv
sim/pcie_tx_checker.sv
sim/pcie_tx_tb.sv

// File: logic/axis_tx_out.sv
// core side stream output

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module axis_tx_out (
    input  logic                          PCIE_CLK,
    input  logic                          PCIE_RST,
    input  pcie_tx_pkg::tx_beat_t         rd_beat,   // fifo head
    input  logic                          empty,
    input  logic                          tready,    // core ready
    output logic                          rd_en,     // pop fifo head
    output logic [`PCIE_TX_DATA_W-1:0]    tdata,
    output logic [`PCIE_TX_KEEP_W-1:0]    tkeep,
    output logic                          tvalid,
    output logic                          tlast
);

    localparam int BPM = `PCIE_TX_KEEP_W / `PCIE_TX_MASK_W;  // keep bits per mask bit

    logic [`PCIE_TX_KEEP_W-1:0] keep;                // widened mask

    assign rd_en = tready && !empty;                 // one beat per ready cycle

    always_comb begin
        for (int i = 0; i < `PCIE_TX_MASK_W; i++) begin
            keep[i*BPM +: BPM] = {BPM{rd_beat.mask[i]}};  // mask[1] -> upper bytes
        end
    end

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            tvalid <= 1'b0;
            tdata  <= '0;
            tkeep  <= '0;
            tlast  <= 1'b0;
        end else begin
            tvalid <= rd_en;                         // drops a cycle after ready
            tdata  <= rd_beat.data;
            tkeep  <= keep;
            tlast  <= rd_beat.eop && rd_en;          // never without valid
        end
    end

endmodule

`default_nettype wire

// File: logic/pcie_tx.sv
// pcie transmit packet arbiter top

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module pcie_tx (
    input  logic                                      PCIE_CLK,
    input  logic                                      PCIE_RST,
    input  logic                                      tx_en,   // transmit enable
    input  pcie_tx_pkg::tx_chan_t [`PCIE_TX_NUM_CH-1:0] chan,  // packet sources
    output logic [`PCIE_TX_NUM_CH-1:0]                ack,     // grant pulses
    output logic [`PCIE_TX_DATA_W-1:0]                tdata,   // to pcie core
    output logic [`PCIE_TX_KEEP_W-1:0]                tkeep,
    output logic                                      tvalid,
    output logic                                      tlast,
    input  logic                                      tready
);

    // ======================================================================
    // internal nets
    // ======================================================================

    logic [`PCIE_TX_NUM_CH-1:0] req;                 // split out of chan
    logic [`PCIE_TX_NUM_CH-1:0] eop;
    logic [`PCIE_TX_NUM_CH-1:0] grant;               // one-hot owner
    logic                       buf_afull;
    logic                       buf_empty;
    logic                       buf_rd;
    pcie_tx_pkg::buf_wr_t       buf_wr;              // capture -> fifo
    pcie_tx_pkg::tx_beat_t      buf_head;            // fifo -> output

    always_comb begin
        for (int i = 0; i < `PCIE_TX_NUM_CH; i++) begin
            req[i] = chan[i].req;
            eop[i] = chan[i].beat.eop;               // sources tie eop to dvld
        end
    end

    // ======================================================================
    // stages
    // ======================================================================

    tx_arbiter i_arb (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .tx_en     (tx_en),
        .req       (req),
        .eop       (eop),
        .buf_afull (buf_afull),
        .grant     (grant),
        .ack       (ack)
    );

    tx_beat_capture i_cap (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .grant     (grant),
        .chan      (chan),
        .buf_wr    (buf_wr)
    );

    tx_fifo #(
        .DEPTH     (`PCIE_TX_FIFO_DEPTH),
        .AFULL_LVL (`PCIE_TX_AFULL_LVL)
    ) i_fifo (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .buf_wr    (buf_wr),
        .rd_en     (buf_rd),
        .rd_beat   (buf_head),
        .empty     (buf_empty),
        .afull     (buf_afull)
    );

    axis_tx_out i_out (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .rd_beat   (buf_head),
        .empty     (buf_empty),
        .tready    (tready),
        .rd_en     (buf_rd),
        .tdata     (tdata),
        .tkeep     (tkeep),
        .tvalid    (tvalid),
        .tlast     (tlast)
    );

endmodule

`default_nettype wire

// File: logic/pcie_tx_cfg.svh
// pcie tx arbiter configuration

`ifndef PCIE_TX_CFG_SVH
`define PCIE_TX_CFG_SVH

// ==========================================================================
// sources and beat format
// ==========================================================================

`define PCIE_TX_NUM_CH      4       // packet sources, ch0 = completions
`define PCIE_TX_DATA_W      64      // beat payload bits
`define PCIE_TX_MASK_W      2       // one bit per 32-bit half
`define PCIE_TX_KEEP_W      8       // byte enables toward the core

// ==========================================================================
// transmit buffer and pipeline
// ==========================================================================

`define PCIE_TX_FIFO_DEPTH  64      // beats
`define PCIE_TX_AFULL_LVL   48      // no new grant at or above this
`define PCIE_TX_DLY_STAGES  2       // registers after capture

`endif

// File: logic/pcie_tx_pkg.sv
// pcie tx shared types

`default_nettype none

`include "pcie_tx_cfg.svh"

package pcie_tx_pkg;

    // one beat as it travels to the core, 68 bits
    typedef struct packed {
        logic                         sop;      // first beat of packet
        logic                         eop;      // last beat of packet
        logic [`PCIE_TX_MASK_W-1:0]   mask;     // bit1 = upper dword valid
        logic [`PCIE_TX_DATA_W-1:0]   data;
    } tx_beat_t;

    // inputs of one packet source
    typedef struct packed {
        logic       req;                        // level, held until ack
        logic       dvld;                       // beat below is valid
        tx_beat_t   beat;
    } tx_chan_t;

    // one write into the transmit buffer
    typedef struct packed {
        logic       wr;                         // write strobe
        tx_beat_t   beat;
    } buf_wr_t;

endpackage

`default_nettype wire

// File: logic/tx_arbiter.sv
// fixed priority tx arbiter

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module tx_arbiter (
    input  logic                          PCIE_CLK,
    input  logic                          PCIE_RST,
    input  logic                          tx_en,      // global transmit enable
    input  logic [`PCIE_TX_NUM_CH-1:0]    req,        // request levels
    input  logic [`PCIE_TX_NUM_CH-1:0]    eop,        // per source end of packet
    input  logic                          buf_afull,  // buffer nearly full
    output logic [`PCIE_TX_NUM_CH-1:0]    grant,      // one-hot owner, zero = idle
    output logic [`PCIE_TX_NUM_CH-1:0]    ack         // one-cycle pulses
);

    // ======================================================================
    // winner selection
    // ======================================================================

    logic [`PCIE_TX_NUM_CH-1:0] win;                  // lowest set request bit
    logic                       idle;                 // no owner right now
    logic                       can_grant;            // new owner this edge
    logic                       owner_eop;            // owner ends its packet

    // two's complement trick isolates the lowest requester
    assign win       = req & (~req + 1'b1);           // ch0 wins over all others
    assign idle      = (grant == '0);
    assign can_grant = idle && tx_en && !buf_afull && (|req);
    assign owner_eop = |(grant & eop);                // only owner's eop counts

    // ======================================================================
    // grant state and acknowledge
    // ======================================================================

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            grant <= '0;
        end else if (can_grant) begin
            grant <= win;                             // owns path from this edge
        end else if (owner_eop) begin
            grant <= '0;                              // back to idle on eop
        end
    end

    // ack is high in the cycle right after the grant edge
    // the source puts its first beat out in that same cycle
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            ack <= '0;
        end else begin
            ack <= can_grant ? win : '0;              // single pulse per grant
        end
    end

endmodule

`default_nettype wire

// File: logic/tx_beat_capture.sv
// granted beat capture and delay line

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module tx_beat_capture (
    input  logic                                      PCIE_CLK,
    input  logic                                      PCIE_RST,
    input  logic [`PCIE_TX_NUM_CH-1:0]                grant,   // one-hot owner
    input  pcie_tx_pkg::tx_chan_t [`PCIE_TX_NUM_CH-1:0] chan,  // all sources
    output pcie_tx_pkg::buf_wr_t                      buf_wr   // toward the fifo
);

    // ======================================================================
    // source select
    // ======================================================================

    pcie_tx_pkg::tx_chan_t                              sel;   // owner's inputs
    pcie_tx_pkg::buf_wr_t                               cap_q; // capture register
    pcie_tx_pkg::buf_wr_t [`PCIE_TX_DLY_STAGES-1:0]     dly_q; // delay line

    // grant is one-hot so at most one source passes
    always_comb begin
        sel = '0;                                     // idle gives a zero write
        for (int i = 0; i < `PCIE_TX_NUM_CH; i++) begin
            if (grant[i]) begin
                sel = chan[i];
            end
        end
    end

    // ======================================================================
    // capture and delay
    // ======================================================================

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            cap_q <= '0;
        end else begin
            cap_q.wr   <= sel.dvld;                   // invalid beats never written
            cap_q.beat <= sel.beat;
        end
    end

    // beat sampled at edge E reaches the fifo write port for edge E+3
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            dly_q <= '0;
        end else begin
            dly_q[0] <= cap_q;
            for (int i = 1; i < `PCIE_TX_DLY_STAGES; i++) begin
                dly_q[i] <= dly_q[i-1];               // shift one stage
            end
        end
    end

    assign buf_wr = dly_q[`PCIE_TX_DLY_STAGES-1];     // oldest stage

endmodule

`default_nettype wire

// File: logic/tx_fifo.sv
// synchronous transmit buffer

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module tx_fifo #(
    parameter int DEPTH     = `PCIE_TX_FIFO_DEPTH,   // beats
    parameter int AFULL_LVL = `PCIE_TX_AFULL_LVL     // grant stop level
) (
    input  logic                    PCIE_CLK,
    input  logic                    PCIE_RST,
    input  pcie_tx_pkg::buf_wr_t    buf_wr,          // from capture stage
    input  logic                    rd_en,           // pop head beat
    output pcie_tx_pkg::tx_beat_t   rd_beat,         // head, valid before pop
    output logic                    empty,
    output logic                    afull            // registered level
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    // ======================================================================
    // storage and pointers
    // ======================================================================

    pcie_tx_pkg::tx_beat_t  mem [DEPTH];             // beat storage
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [CW-1:0]          count;                   // occupancy in beats
    logic [CW-1:0]          count_nxt;
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr   = buf_wr.wr && (count != CW'(DEPTH));  // full never hit in use
    assign do_rd   = rd_en && !empty;
    assign empty   = (count == '0);
    assign rd_beat = mem[rd_ptr];                    // show-ahead read

    always_comb begin
        count_nxt = count + CW'(do_wr) - CW'(do_rd);
    end

    always_ff @(posedge PCIE_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= buf_wr.beat;
        end
    end

    // ======================================================================
    // control
    // ======================================================================

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            afull  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_nxt;
            afull <= (count_nxt >= CW'(AFULL_LVL));   // moves with the count
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the pcie tx testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module pcie_tx_tb \
    -f build.f \
    -Mdir obj_dir -o pcie_tx_sim

# exit status of the simulation decides pass or fail
./obj_dir/pcie_tx_sim

// File: sim/pcie_tx_checker.sv
// pcie tx protocol checker

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module pcie_tx_checker (
    input  logic                          PCIE_CLK,
    input  logic                          PCIE_RST,
    input  logic                          tx_en,
    input  logic [`PCIE_TX_NUM_CH-1:0]    ack,
    input  logic                          tvalid,
    input  logic                          tlast
);

    // ==========================================================================
    // acknowledge rules
    // ==========================================================================

    ack_onehot: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        $onehot0(ack))
        else $error("more than one acknowledge at once");

    ack_pulse: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        (|ack) |=> (ack == '0))                       // single cycle only
        else $error("acknowledge held longer than one cycle");

    ack_needs_en: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        (|ack) |-> $past(tx_en))                      // grant edge saw tx_en
        else $error("acknowledge given while tx_en low");

    // ==========================================================================
    // core side
    // ==========================================================================

    last_with_valid: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        tlast |-> tvalid)
        else $error("tlast without tvalid");

    valid_in_reset: assert property (@(posedge PCIE_CLK) PCIE_RST |-> !tvalid)
        else $error("tvalid high during reset");

endmodule

`default_nettype wire

// File: sim/pcie_tx_tb.sv
// pcie tx arbiter testbench

`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_cfg.svh"

module pcie_tx_tb;

    localparam int NUM_CH    = `PCIE_TX_NUM_CH;
    localparam int NUM_TESTS = 9;
    localparam int MAX_LEN   = 16;                    // room for any 4-bit length

    typedef struct packed {
        logic [3:0]       req_mask;                   // channels that request
        logic [3:0][3:0]  len;                        // beats per channel
        logic [1:0]       last_mask;                  // mask of the final beat
        logic [3:0]       gap_pat;                    // 1 = no data in that cycle mod 4
        logic             gap_rnd;                    // lfsr gaps instead
        logic             en;                         // tx_en at test start
        logic             rdy_rnd;                    // lfsr ready
        logic             rdy_val;                    // held ready level
        logic             blk;                        // afull blocking phase
    } test_t;

    // ==========================================================================
    // dut, checker and clock
    // ==========================================================================

    logic                               PCIE_CLK;
    logic                               PCIE_RST;
    logic                               tx_en;
    pcie_tx_pkg::tx_chan_t [NUM_CH-1:0] chan;
    logic [NUM_CH-1:0]                  ack;
    logic [`PCIE_TX_DATA_W-1:0]         tdata;
    logic [`PCIE_TX_KEEP_W-1:0]         tkeep;
    logic                               tvalid;
    logic                               tlast;
    logic                               tready;

    pcie_tx i_pcie_tx (
        .PCIE_CLK (PCIE_CLK),
        .PCIE_RST (PCIE_RST),
        .tx_en    (tx_en),
        .chan     (chan),
        .ack      (ack),
        .tdata    (tdata),
        .tkeep    (tkeep),
        .tvalid   (tvalid),
        .tlast    (tlast),
        .tready   (tready)
    );

    bind pcie_tx pcie_tx_checker i_checker (
        .PCIE_CLK (PCIE_CLK),
        .PCIE_RST (PCIE_RST),
        .tx_en    (tx_en),
        .ack      (ack),
        .tvalid   (tvalid),
        .tlast    (tlast)
    );

    always #20 PCIE_CLK = ~PCIE_CLK;                  // 40 ns period

    test_t                  tbl [NUM_TESTS];          // stimulus table
    test_t                  cfg;                      // current entry
    logic                   en_cfg;
    logic                   rdy_cfg;
    logic [31:0]            lfsr;
    logic [NUM_CH-1:0]      want;                     // raise req at next fall
    logic [NUM_CH-1:0]      sending;                  // source owns the path
    int                     pkt_len  [NUM_CH];
    int                     beat_idx [NUM_CH];
    pcie_tx_pkg::tx_beat_t  pkt [NUM_CH][MAX_LEN];    // beats of current packet
    pcie_tx_pkg::tx_beat_t  exp_q [$];                // scoreboard in output order
    int                     ack_cnt;
    int                     out_cnt;
    int                     cyc;

    // ==========================================================================
    // helpers
    // ==========================================================================

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], next_bit()};                // one step per bit
        end
        return v;
    endfunction

    // each mask bit covers four bytes with bit 1 on the upper half
    function automatic logic [`PCIE_TX_KEEP_W-1:0] widen_mask(input logic [1:0] m);
        return {{4{m[1]}}, {4{m[0]}}};
    endfunction

    task automatic stop_fail();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        stop_fail();
    endtask

    // ==========================================================================
    // source models and scoreboard on the falling edge
    // ==========================================================================

    task automatic check_output();
        pcie_tx_pkg::tx_beat_t want_beat;
        if (tvalid) begin
            assert (exp_q.size() != 0) else report_error("output beat with none expected");
            want_beat = exp_q.pop_front();
            assert (tdata == want_beat.data)
                else report_error($sformatf("tdata %h, expected %h", tdata, want_beat.data));
            assert (tkeep == widen_mask(want_beat.mask))
                else report_error($sformatf("tkeep %h, expected %h", tkeep,
                                            widen_mask(want_beat.mask)));
            assert (tlast == want_beat.eop)
                else report_error($sformatf("tlast %b, expected %b", tlast, want_beat.eop));
            out_cnt++;
        end
    endtask

    task automatic build_packet(input int ch);
        for (int k = 0; k < pkt_len[ch]; k++) begin
            pkt[ch][k].sop  = (k == 0);
            pkt[ch][k].eop  = (k == pkt_len[ch] - 1);
            pkt[ch][k].mask = pkt[ch][k].eop ? cfg.last_mask : 2'b11;
            pkt[ch][k].data = take_bits(64);
            exp_q.push_back(pkt[ch][k]);              // packets leave in ack order
        end
    endtask

    task automatic accept_acks();
        int lowest;
        lowest = -1;
        for (int i = NUM_CH - 1; i >= 0; i--) begin
            if (chan[i].req) lowest = i;              // fixed priority winner
        end
        for (int i = 0; i < NUM_CH; i++) begin
            if (ack[i]) begin
                assert (i == lowest)
                    else report_error($sformatf("ack on ch%0d, expected ch%0d", i, lowest));
                build_packet(i);
                chan[i].req = 1'b0;
                sending[i]  = 1'b1;
                beat_idx[i] = 0;
                ack_cnt++;
            end
        end
    endtask

    task automatic drive_sources();
        logic gap;
        for (int i = 0; i < NUM_CH; i++) begin
            chan[i].dvld = 1'b0;
            chan[i].beat = '0;
            if (want[i]) begin
                chan[i].req = 1'b1;
                want[i]     = 1'b0;
            end
            if (sending[i]) begin
                gap = cfg.gap_rnd ? next_bit() : cfg.gap_pat[cyc % 4];
                if (gap) begin
                    chan[i].beat.data = 64'hbad0_bad0_bad0_bad0;  // must never show up
                end else begin
                    chan[i].dvld = 1'b1;
                    chan[i].beat = pkt[i][beat_idx[i]];
                    if (beat_idx[i] == pkt_len[i] - 1) sending[i] = 1'b0;
                    else beat_idx[i]++;
                end
            end
        end
        tx_en  = en_cfg;
        tready = cfg.rdy_rnd ? next_bit() : rdy_cfg;
        cyc++;
    endtask

    always @(negedge PCIE_CLK) begin
        check_output();
        accept_acks();
        drive_sources();
    end

    // ==========================================================================
    // test sequence
    // ==========================================================================

    task automatic run_test(input test_t t);
        int n_req;
        int ack_base;
        int out_base;
        @(posedge PCIE_CLK);
        cfg      = t;
        en_cfg   = t.en;
        rdy_cfg  = t.rdy_val;
        ack_base = ack_cnt;
        out_base = out_cnt;
        n_req    = $countones(t.req_mask);
        for (int i = 0; i < NUM_CH; i++) begin
            pkt_len[i] = int'(t.len[i]);
            if (t.req_mask[i]) want[i] = 1'b1;
        end
        if (!t.en) begin
            repeat (24) @(posedge PCIE_CLK);
            assert (ack_cnt == ack_base && out_cnt == out_base)
                else report_error("activity while tx_en low");
            en_cfg = 1'b1;
        end
        if (t.blk) begin
            while (ack_cnt != ack_base + n_req || sending != '0) @(posedge PCIE_CLK);
            repeat (8) @(posedge PCIE_CLK);           // pipeline settles into fifo
            want[0] = 1'b1;
            repeat (30) @(posedge PCIE_CLK);
            assert (ack_cnt == ack_base + n_req && out_cnt == out_base)
                else report_error("grant given with buffer almost full");
            rdy_cfg = 1'b1;
            n_req++;
        end
        while (ack_cnt != ack_base + n_req || sending != '0 || exp_q.size() != 0) begin
            @(posedge PCIE_CLK);
        end
        repeat (4) @(posedge PCIE_CLK);
    endtask

    initial begin
        PCIE_CLK = 1'b0;
        PCIE_RST = 1'b1;
        tx_en    = 1'b0;
        tready   = 1'b0;
        chan     = '0;
        cfg      = '0;
        en_cfg   = 1'b0;
        rdy_cfg  = 1'b0;
        lfsr     = 32'h4bed_0a52;
        want     = '0;
        sending  = '0;
        ack_cnt  = 0;
        out_cnt  = 0;
        cyc      = 0;
        // req  | len 3210 | last | gap  | grnd | en | rrnd | rdy | blk
        tbl[0] = {4'b0001, 16'h0001, 2'b01, 4'b0000, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        tbl[1] = {4'b0010, 16'h0030, 2'b11, 4'b0000, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        tbl[2] = {4'b0100, 16'h0500, 2'b01, 4'b0100, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        tbl[3] = {4'b1000, 16'hc000, 2'b10, 4'b0000, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        tbl[4] = {4'b1111, 16'h6342, 2'b11, 4'b0000, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        tbl[5] = {4'b1010, 16'h2040, 2'b01, 4'b0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        tbl[6] = {4'b1111, 16'hcccc, 2'b11, 4'b0000, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
        tbl[7] = {4'b1111, 16'h597c, 2'b10, 4'b0000, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
        tbl[8] = {4'b0101, 16'h0b08, 2'b01, 4'b1010, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
        repeat (8) @(negedge PCIE_CLK);
        PCIE_RST = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(tbl[t]);
        end
        $display("all tests passed");
        $finish;
    end

    // watchdog allows 400 cycles per table entry
    initial begin
        repeat (NUM_TESTS * 400) @(posedge PCIE_CLK);
        $display("watchdog expired after %0d cycles, run did not finish", NUM_TESTS * 400);
        stop_fail();
    end

endmodule

`default_nettype wire
